//--- fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first pc fetched after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// memory word = low address bits xor this pattern
`define FETCH_INST_PATTERN 32'h5a3c_96e1

// longest request to response delay, in cycles
`define FETCH_MEM_MAX_LAT 4

`endif

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // byte address or program counter
    typedef logic [63:0] addr_t;

    // one uncompressed instruction
    typedef logic [31:0] inst_t;

    // fetch sequencer states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } fetch_state_e;

endpackage

`default_nettype wire

//--- pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module pc_select
    import fetch_pkg::*;
(
    input  logic  me_jal_i,
    input  logic  me_jalr_i,
    input  logic  me_branch_i,
    input  logic  trap_i,
    input  addr_t me_alu_res_i,
    input  addr_t me_pc_i,
    input  addr_t me_imm_i,
    input  addr_t me_r1data_i,
    input  addr_t mtvec_i,
    output logic  redirect_o,
    output addr_t redirect_pc_o
);

    logic  take_branch;
    addr_t jalr_sum;

    // branch compare result arrives as a zero test on the alu output
    assign take_branch = me_branch_i && (me_alu_res_i == '0);
    assign jalr_sum    = me_r1data_i + me_imm_i;

    // fixed priority: pc-relative, then jalr, then trap
    always_comb begin
        redirect_o    = 1'b0;
        redirect_pc_o = me_pc_i + me_imm_i;
        if (me_jal_i || take_branch) begin
            redirect_o = 1'b1;
        end else if (me_jalr_i) begin
            redirect_o    = 1'b1;
            redirect_pc_o = {jalr_sum[63:1], 1'b0};
        end else if (trap_i) begin
            redirect_o    = 1'b1;
            redirect_pc_o = mtvec_i;
        end
    end

endmodule

`default_nettype wire

//--- inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module inst_fetch
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  redirect_i,
    input  addr_t redirect_pc_i,
    input  logic  stall_i,
    output logic  req_valid_o,
    output addr_t req_addr_o,
    input  logic  req_ready_i,
    input  logic  resp_valid_i,
    input  inst_t resp_data_i,
    output logic  resp_ready_o,
    output logic  inst_valid_o,
    output inst_t inst_o,
    output addr_t pc_o
);

    fetch_state_e state_q;
    addr_t        pc_q;
    addr_t        pc_next;
    addr_t        req_addr_q;
    logic         stale_q;
    logic         accept;
    logic         resp_fire;
    logic         resp_keep;

    // decode takes the buffered instruction
    assign accept = inst_valid_o && !stall_i;

    // stale data is drained even when the output buffer is full
    assign resp_ready_o = (state_q == WAIT)
                        && (stale_q || redirect_i || !inst_valid_o || accept);
    assign resp_fire    = resp_valid_i && resp_ready_o;
    assign resp_keep    = resp_fire && !stale_q && !redirect_i;

    assign req_valid_o = (state_q == REQ);
    assign req_addr_o  = req_addr_q;

    // pc of the next instruction decode will see
    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (accept) begin
            pc_next = pc_q + 64'd4;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            pc_q    <= `FETCH_RESET_PC;
            stale_q <= 1'b0;
        end else begin
            pc_q <= pc_next;
            case (state_q)
                IDLE: state_q <= REQ;
                REQ: begin
                    if (req_ready_i) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (resp_fire) begin
                        state_q <= REQ;
                    end
                end
                default: state_q <= IDLE;
            endcase
            // a redirect orphans whatever request is in flight
            if (resp_fire) begin
                stale_q <= 1'b0;
            end else if (redirect_i && state_q != IDLE) begin
                stale_q <= 1'b1;
            end
        end
    end

    // kept word: prefetch the one after it, otherwise refetch from pc
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            req_addr_q <= pc_next;
        end else if (resp_fire) begin
            req_addr_q <= resp_keep ? req_addr_q + 64'd4 : pc_next;
        end
    end

    // output buffer to decode
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_valid_o <= 1'b0;
        end else if (redirect_i) begin
            inst_valid_o <= 1'b0;
        end else if (resp_keep) begin
            inst_valid_o <= 1'b1;
        end else if (accept) begin
            inst_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_keep) begin
            inst_o <= resp_data_i;
            pc_o   <= req_addr_q;
        end
    end

    a_hold_under_stall: assert property (@(posedge clk) disable iff (reset_i)
        inst_valid_o && stall_i |=> $stable(inst_o) && $stable(pc_o));

    a_req_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_addr_o));

endmodule

`default_nettype wire

//--- inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module inst_mem
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  req_valid_i,
    input  addr_t req_addr_i,
    output logic  req_ready_o,
    output logic  resp_valid_o,
    output inst_t resp_data_o,
    input  logic  resp_ready_i
);

    localparam int LAT_W = $clog2(`FETCH_MEM_MAX_LAT + 1);

    logic             pending_q;
    logic [LAT_W-1:0] count_q;
    logic [LAT_W-1:0] lat_q;
    logic             req_fire;
    logic             resp_fire;
    logic             outstanding_q;

    assign req_fire  = req_valid_i && req_ready_o;
    assign resp_fire = resp_valid_o && resp_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_ready_o  <= 1'b0;
            resp_valid_o <= 1'b0;
            pending_q    <= 1'b0;
            count_q      <= '0;
            lat_q        <= LAT_W'(1);
        end else if (req_fire) begin
            req_ready_o <= 1'b0;
            pending_q   <= 1'b1;
            count_q     <= lat_q;
            // delay rotates 1..max so response timing keeps changing
            lat_q <= (lat_q == LAT_W'(`FETCH_MEM_MAX_LAT)) ? LAT_W'(1) : lat_q + 1'b1;
        end else if (pending_q) begin
            if (count_q == LAT_W'(1)) begin
                pending_q    <= 1'b0;
                resp_valid_o <= 1'b1;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end else if (!resp_valid_o || resp_ready_i) begin
            resp_valid_o <= 1'b0;
            req_ready_o  <= 1'b1;
        end
    end

    // word is fixed at accept and held until taken
    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp_data_o <= req_addr_i[31:0] ^ `FETCH_INST_PATTERN;
        end
    end

    // independent count of accepted but unanswered requests
    always_ff @(posedge clk) begin
        if (reset_i) begin
            outstanding_q <= 1'b0;
        end else if (req_fire) begin
            outstanding_q <= 1'b1;
        end else if (resp_fire) begin
            outstanding_q <= 1'b0;
        end
    end

    a_resp_has_req: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_o |-> outstanding_q);

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  me_jal_i,
    input  logic  me_jalr_i,
    input  logic  me_branch_i,
    input  addr_t me_alu_res_i,
    input  addr_t me_pc_i,
    input  addr_t me_imm_i,
    input  addr_t me_r1data_i,
    input  logic  trap_i,
    input  addr_t mtvec_i,
    input  logic  stall_i,
    output logic  inst_valid_o,
    output inst_t inst_o,
    output addr_t pc_o
);

    logic  redirect;
    addr_t redirect_pc;

    // fetch to memory channels
    logic  req_valid;
    addr_t req_addr;
    logic  req_ready;
    logic  resp_valid;
    inst_t resp_data;
    logic  resp_ready;

    pc_select i_pc_select (
        .me_jal_i      (me_jal_i),
        .me_jalr_i     (me_jalr_i),
        .me_branch_i   (me_branch_i),
        .trap_i        (trap_i),
        .me_alu_res_i  (me_alu_res_i),
        .me_pc_i       (me_pc_i),
        .me_imm_i      (me_imm_i),
        .me_r1data_i   (me_r1data_i),
        .mtvec_i       (mtvec_i),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    inst_fetch i_inst_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .stall_i       (stall_i),
        .req_valid_o   (req_valid),
        .req_addr_o    (req_addr),
        .req_ready_i   (req_ready),
        .resp_valid_i  (resp_valid),
        .resp_data_i   (resp_data),
        .resp_ready_o  (resp_ready),
        .inst_valid_o  (inst_valid_o),
        .inst_o        (inst_o),
        .pc_o          (pc_o)
    );

    inst_mem i_inst_mem (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .resp_ready_i (resp_ready)
    );

endmodule

`default_nettype wire

//--- fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_checker
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  logic         me_jal_i,
    input  logic         me_jalr_i,
    input  logic         me_branch_i,
    input  addr_t        me_alu_res_i,
    input  addr_t        me_pc_i,
    input  addr_t        me_imm_i,
    input  addr_t        me_r1data_i,
    input  logic         trap_i,
    input  addr_t        mtvec_i,
    input  logic         stall_i,
    input  logic         inst_valid_i,
    input  inst_t        inst_i,
    input  addr_t        pc_i,
    input  fetch_state_e fetch_state_i,
    input  logic         test_done_i,
    input  int           test_id_i,
    output int           tests_passed_o,
    output int           tests_failed_o
);

    addr_t       exp_pc;
    addr_t       held_pc;
    inst_t       held_inst;
    logic        held_q;
    logic        held_redirect_q;
    logic [64:0] target;
    int          errors = 0;
    int          accepts;

    // {taken, target}: pc-relative first, then jalr, then trap
    function automatic logic [64:0] target_of(input logic jal, input logic jalr,
                                              input logic branch, input logic trap,
                                              input addr_t alu, input addr_t pc,
                                              input addr_t imm, input addr_t r1,
                                              input addr_t vec);
        addr_t sum;
        sum = r1 + imm;
        if (jal || (branch && alu == 64'd0)) begin
            return {1'b1, pc + imm};
        end
        if (jalr) begin
            return {1'b1, sum[63:1], 1'b0};
        end
        if (trap) begin
            return {1'b1, vec};
        end
        return {1'b0, 64'd0};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "sequential fetch";
            2: return "random stall";
            3: return "branch";
            4: return "jal and jalr";
            5: return "trap";
            6: return "random mix";
            default: return "unknown";
        endcase
    endfunction

    // everything is stable at the falling edge
    always @(negedge clk) begin
        if (reset_i) begin
            exp_pc         = `FETCH_RESET_PC;
            held_q         = 1'b0;
            accepts        = 0;
            tests_passed_o = 0;
            tests_failed_o = 0;
            if (inst_valid_i) begin
                $display("inst_valid_o is high while reset is applied");
                errors++;
            end
        end else begin
            target = target_of(me_jal_i, me_jalr_i, me_branch_i, trap_i, me_alu_res_i,
                               me_pc_i, me_imm_i, me_r1data_i, mtvec_i);
            // stalled instruction must still be there, unchanged
            if (held_q) begin
                if (pc_i !== held_pc) begin
                    $display("[FAIL] pc_o: got %h expected %h under stall", pc_i, held_pc);
                    errors++;
                end
                if (inst_i !== held_inst) begin
                    $display("[FAIL] inst_o: got %h expected %h under stall", inst_i, held_inst);
                    errors++;
                end
                if (!held_redirect_q && !inst_valid_i) begin
                    $display("instruction at pc %h vanished while decode stalled, fetch in %s",
                             held_pc, fetch_state_i.name());
                    errors++;
                end
            end
            // accept is older than a same-cycle redirect
            if (inst_valid_i && !stall_i) begin
                accepts++;
                if (pc_i !== exp_pc) begin
                    $display("[FAIL] pc_o: got %h expected %h", pc_i, exp_pc);
                    errors++;
                end
                if (inst_i !== (exp_pc[31:0] ^ `FETCH_INST_PATTERN)) begin
                    $display("[FAIL] inst_o: got %h expected %h", inst_i,
                             exp_pc[31:0] ^ `FETCH_INST_PATTERN);
                    errors++;
                end
                exp_pc = exp_pc + 64'd4;
            end
            if (target[64]) begin
                exp_pc = target[63:0];
            end
            held_q          = inst_valid_i && stall_i;
            held_redirect_q = target[64];
            held_pc         = pc_i;
            held_inst       = inst_i;
            if (test_done_i) begin
                $display("test %0d (%s): %0d accepted, %0d errors, %s", test_id_i,
                         test_name(test_id_i), accepts, errors, errors == 0 ? "pass" : "fail");
                if (errors == 0) begin
                    tests_passed_o++;
                end else begin
                    tests_failed_o++;
                end
                errors  = 0;
                accepts = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch
    import fetch_pkg::*;
();

    localparam int NUM_TESTS = 6;
    // each test stays within 30 fetches at the slowest memory delay
    localparam int CYCLES_PER_TEST = 30 * (`FETCH_MEM_MAX_LAT + 1);
    localparam int TIMEOUT_CYCLES = NUM_TESTS * CYCLES_PER_TEST;

    logic  clk;
    logic  reset_i;
    logic  me_jal_i;
    logic  me_jalr_i;
    logic  me_branch_i;
    addr_t me_alu_res_i;
    addr_t me_pc_i;
    addr_t me_imm_i;
    addr_t me_r1data_i;
    logic  trap_i;
    addr_t mtvec_i;
    logic  stall_i;
    logic  inst_valid_o;
    inst_t inst_o;
    addr_t pc_o;

    integer      seed;
    logic [31:0] rnd;
    int          goal;
    int          accept_count;
    int          cycle_count;
    int          tests_passed;
    int          tests_failed;
    logic        test_done;
    int          test_id;

    fetch_top i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .me_jal_i     (me_jal_i),
        .me_jalr_i    (me_jalr_i),
        .me_branch_i  (me_branch_i),
        .me_alu_res_i (me_alu_res_i),
        .me_pc_i      (me_pc_i),
        .me_imm_i     (me_imm_i),
        .me_r1data_i  (me_r1data_i),
        .trap_i       (trap_i),
        .mtvec_i      (mtvec_i),
        .stall_i      (stall_i),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .pc_o         (pc_o)
    );

    fetch_checker i_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .me_jal_i       (me_jal_i),
        .me_jalr_i      (me_jalr_i),
        .me_branch_i    (me_branch_i),
        .me_alu_res_i   (me_alu_res_i),
        .me_pc_i        (me_pc_i),
        .me_imm_i       (me_imm_i),
        .me_r1data_i    (me_r1data_i),
        .trap_i         (trap_i),
        .mtvec_i        (mtvec_i),
        .stall_i        (stall_i),
        .inst_valid_i   (inst_valid_o),
        .inst_i         (inst_o),
        .pc_i           (pc_o),
        .fetch_state_i  (i_dut.i_inst_fetch.state_q),
        .test_done_i    (test_done),
        .test_id_i      (test_id),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before all tests finished", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // count the accept of this cycle, then move to the next drive point
    task automatic next_cycle();
        @(negedge clk);
        if (inst_valid_o && !stall_i) begin
            accept_count++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic clear_controls();
        me_jal_i     = 1'b0;
        me_jalr_i    = 1'b0;
        me_branch_i  = 1'b0;
        trap_i       = 1'b0;
        stall_i      = 1'b0;
        me_alu_res_i = 64'd0;
        me_pc_i      = 64'd0;
        me_imm_i     = 64'd0;
        me_r1data_i  = 64'd0;
        mtvec_i      = 64'd0;
    endtask

    task automatic wait_accepts(input int n);
        int target;
        target = accept_count + n;
        while (accept_count < target) begin
            next_cycle();
        end
    endtask

    // memory-stage inputs held for exactly one cycle
    task automatic pulse_redirect(input logic jal, input logic jalr, input logic branch,
                                  input logic trap, input addr_t alu, input addr_t pc,
                                  input addr_t imm, input addr_t r1, input addr_t vec);
        me_jal_i     = jal;
        me_jalr_i    = jalr;
        me_branch_i  = branch;
        trap_i       = trap;
        me_alu_res_i = alu;
        me_pc_i      = pc;
        me_imm_i     = imm;
        me_r1data_i  = r1;
        mtvec_i      = vec;
        next_cycle();
        clear_controls();
    endtask

    task automatic finish_test(input int id);
        clear_controls();
        test_id   = id;
        test_done = 1'b1;
        next_cycle();
        test_done = 1'b0;
    endtask

    // word aligned address inside the low megabyte above the reset pc
    function automatic addr_t random_target();
        logic [31:0] r;
        r = $random(seed);
        return {32'h0, 32'h8000_0000 | (r & 32'h000f_fffc)};
    endfunction

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        seed         = 32'ha2de;
        test_done    = 1'b0;
        test_id      = 0;
        accept_count = 0;
        cycle_count  = 0;
        clear_controls();
        repeat (10) @(posedge clk);
        #2;
        reset_i = 1'b0;

        wait_accepts(20);
        finish_test(1);

        goal = accept_count + 20;
        while (accept_count < goal) begin
            rnd     = $random(seed);
            stall_i = rnd[0];
            next_cycle();
        end
        finish_test(2);

        // taken, then not taken
        wait_accepts(3);
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'h0, 64'h8000_0800, 64'h800, 64'h0, 64'h0);
        wait_accepts(4);
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'h5, 64'h8000_0100, 64'h40, 64'h0, 64'h0);
        wait_accepts(4);
        finish_test(3);

        pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 64'h0, 64'h8000_2000, 64'h40, 64'h0, 64'h0);
        wait_accepts(3);
        pulse_redirect(1'b0, 1'b1, 1'b0, 1'b0, 64'h0, 64'h0, 64'h10, 64'h8000_3001, 64'h0);
        wait_accepts(3);
        pulse_redirect(1'b1, 1'b1, 1'b0, 1'b0, 64'h0, 64'h8000_4000, 64'h20, 64'h8000_6001,
                       64'h0);
        wait_accepts(3);
        finish_test(4);

        pulse_redirect(1'b0, 1'b0, 1'b0, 1'b1, 64'h0, 64'h0, 64'h0, 64'h0, 64'h8000_5000);
        wait_accepts(3);
        pulse_redirect(1'b0, 1'b1, 1'b0, 1'b1, 64'h0, 64'h0, 64'h0, 64'h8000_7005,
                       64'h8000_8000);
        wait_accepts(3);
        finish_test(5);

        // redirects land in any fetch state
        goal = accept_count + 25;
        while (accept_count < goal) begin
            rnd = $random(seed);
            clear_controls();
            stall_i = (rnd[1:0] == 2'd0);
            if (rnd[4:2] == 3'd0) begin
                case (rnd[6:5])
                    2'd0: begin
                        me_jal_i = 1'b1;
                        me_pc_i  = random_target();
                        me_imm_i = 64'h40;
                    end
                    2'd1: begin
                        me_jalr_i   = 1'b1;
                        me_r1data_i = random_target() | 64'd1;
                        me_imm_i    = 64'h100;
                    end
                    2'd2: begin
                        me_branch_i  = 1'b1;
                        me_alu_res_i = rnd[7] ? 64'd0 : {56'h0, rnd[15:8]};
                        me_pc_i      = random_target();
                        me_imm_i     = 64'h80;
                    end
                    default: begin
                        trap_i  = 1'b1;
                        mtvec_i = random_target();
                    end
                endcase
            end
            next_cycle();
        end
        finish_test(6);

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == NUM_TESTS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
fetch_pkg.sv
pc_select.sv
inst_fetch.sv
inst_mem.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_fetch -f all.f -o tb_fetch \
    && ./obj_dir/tb_fetch > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
